/* Bender.yml */
package:
  name: pet_bus

export_include_dirs:
  - hw

sources:
  - files:
      - hw/pet_pkg.sv
      - hw/bus_timing.sv
      - hw/cpu_port.sv
      - hw/host_port.sv
      - hw/bus_arbiter.sv
      - hw/pet_ram.sv
      - hw/pet_bus.sv
  - target: test
    files:
      - dv/pet_bus_tb.sv

/* dv/pet_bus_tb.sv */
// Self-checking testbench for the PET bus core.
// Random stimulus comes from a fixed seed. A byte array models the shared RAM.
// The RAM powers up undefined, so reads only go to addresses written earlier.
// The run stops at the first error. A watchdog bounds the run time.

`include "pet_config.svh"

module pet_bus_tb
    import pet_pkg::*;
();

    localparam int AW = `PET_ADDR_WIDTH;
    localparam int DW = `PET_DATA_WIDTH;

    // Worst case is 3000 frames plus 2000 host transfers of up to 20 cycles
    localparam int MAX_FRAMES     = 3000;
    localparam int MAX_HOST_OPS   = 2000;
    localparam int HOST_OP_CYCLES = 20;
    localparam int TIMEOUT_CYCLES =
        2 * (MAX_FRAMES * `PET_FRAME_CYCLES + MAX_HOST_OPS * HOST_OP_CYCLES);

    localparam int MEM_SIZE    = 2 ** AW;
    localparam int ROM_BASE    = int'(`PET_ROM_REGION) << (AW - 4);
    localparam int REGION_SPAN = 'h4000;
    localparam int HOST_BASE   = 'h0000;
    localparam int CPU_BASE    = 'h4000;

    localparam phase_t LAST_PHASE = phase_t'(`PET_FRAME_CYCLES - 1);
    localparam phase_t HIGH_PHASE = phase_t'(`PET_FRAME_CYCLES / 2);

    logic          sys_clock_i;
    logic          rst_i;
    logic          cpu_clock_o;
    logic [AW-1:0] cpu_addr_i;
    logic [DW-1:0] cpu_data_i;
    logic          cpu_we_i;
    logic [DW-1:0] cpu_data_o;
    logic          io_cs_o;
    logic [DW-1:0] io_data_i;
    logic          host_valid_i;
    logic          host_ready_o;
    logic [AW-1:0] host_addr_i;
    logic [DW-1:0] host_wdata_i;
    logic          host_we_i;
    logic          host_rvalid_o;
    logic          host_rready_i;
    logic [DW-1:0] host_rdata_o;

    integer        seed;
    int            cycle_count;
    phase_t        phase_m;
    logic [DW-1:0] mem_model [0:MEM_SIZE-1];
    logic [AW-1:0] written_q [$];
    logic [AW-1:0] low_pool [$];
    logic [AW-1:0] cpu_pool [$];
    logic [AW-1:0] host_pool [$];

    pet_bus pet_bus_inst (
        .sys_clock_i  (sys_clock_i),
        .rst_i        (rst_i),
        .cpu_clock_o  (cpu_clock_o),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_data_i   (cpu_data_i),
        .cpu_we_i     (cpu_we_i),
        .cpu_data_o   (cpu_data_o),
        .io_cs_o      (io_cs_o),
        .io_data_i    (io_data_i),
        .host_valid_i (host_valid_i),
        .host_ready_o (host_ready_o),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_we_i    (host_we_i),
        .host_rvalid_o(host_rvalid_o),
        .host_rready_i(host_rready_i),
        .host_rdata_o (host_rdata_o)
    );

    initial begin
        sys_clock_i = 1'b0;
        forever #20 sys_clock_i = ~sys_clock_i;
    end

    // Frame phase as the timing rules describe it
    always @(posedge sys_clock_i) begin
        if (rst_i) begin
            phase_m <= '0;
        end else begin
            phase_m <= phase_m + phase_t'(1);
        end
    end

    always @(negedge sys_clock_i) begin
        if (!rst_i) begin
            assert (cpu_clock_o == (phase_m >= HIGH_PHASE))
                else report_error($sformatf("cpu_clock_o %b in phase %0d", cpu_clock_o, phase_m));
        end
    end

    task automatic report_error(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic logic [DW-1:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[DW-1:0];
    endfunction

    function automatic int rand_index(input int n);
        logic [31:0] r;
        logic [31:0] span;
        span = n;
        r = $random(seed);
        return int'(r % span);
    endfunction

    function automatic logic [AW-1:0] rand_addr_in(input int base, input int span);
        int a;
        a = base + rand_index(span);
        return a[AW-1:0];
    endfunction

    // One host transfer, with random response stalls
    task automatic host_access(input logic we, input logic [AW-1:0] addr,
                               input logic [DW-1:0] wdata);
        logic          accepted;
        logic          done;
        logic          stalled;
        int            waited;
        logic [DW-1:0] expected;
        logic [DW-1:0] held;
        accepted = 1'b0;
        done     = 1'b0;
        stalled  = 1'b0;
        waited   = 0;
        held     = '0;
        if (we) begin
            expected = wdata;
            mem_model[addr] = wdata;
        end else begin
            expected = mem_model[addr];
        end
        @(posedge sys_clock_i);
        host_valid_i <= 1'b1;
        host_we_i    <= we;
        host_addr_i  <= addr;
        host_wdata_i <= wdata;
        while (!accepted) begin
            @(negedge sys_clock_i);
            accepted = host_ready_o;
            @(posedge sys_clock_i);
            host_rready_i <= rand_bit();
        end
        host_valid_i <= 1'b0;
        while (!done) begin
            @(negedge sys_clock_i);
            waited++;
            assert (!host_ready_o)
                else report_error("host_ready_o high while an access is pending");
            if (host_rvalid_o) begin
                assert (waited >= 2)
                    else report_error("host response less than two cycles after acceptance");
                assert (!stalled || host_rdata_o == held)
                    else report_error($sformatf("host_rdata_o changed under stall, %h to %h",
                                                held, host_rdata_o));
                assert (host_rdata_o == expected)
                    else report_error($sformatf("host_rdata_o %h, expected %h at %h",
                                                host_rdata_o, expected, addr));
                held    = host_rdata_o;
                stalled = !host_rready_i;
                done    = host_rready_i;
            end
            @(posedge sys_clock_i);
            host_rready_i <= rand_bit();
        end
        @(negedge sys_clock_i);
        assert (!host_rvalid_o)
            else report_error("host response still offered after it was accepted");
    endtask

    // One CPU frame, checked in phases 0 to 3
    task automatic cpu_frame(input logic we, input logic [AW-1:0] addr,
                             input logic [DW-1:0] wdata);
        cpu_addr_u     a;
        logic          is_io;
        logic          lands;
        logic [DW-1:0] io_byte;
        logic [DW-1:0] expected;
        a.flat   = addr;
        is_io    = (a.page_view.page == `PET_IO_PAGE);
        lands    = we && !is_io && (a.region_view.region < `PET_ROM_REGION);
        io_byte  = rand_byte();
        expected = is_io ? io_byte : mem_model[addr];
        // Inputs change on the edge that starts phase 0
        @(posedge sys_clock_i);
        while (phase_m != LAST_PHASE) begin
            @(posedge sys_clock_i);
        end
        cpu_addr_i <= addr;
        cpu_data_i <= wdata;
        cpu_we_i   <= we;
        io_data_i  <= io_byte;
        if (lands) begin
            mem_model[addr] = wdata;
        end
        @(negedge sys_clock_i);
        assert (!io_cs_o) else report_error("io_cs_o high in phase 0");
        @(negedge sys_clock_i);
        assert (io_cs_o == is_io)
            else report_error($sformatf("io_cs_o %b in phase 1 at %h", io_cs_o, addr));
        repeat (2) begin
            @(negedge sys_clock_i);
            assert (io_cs_o == is_io)
                else report_error($sformatf("io_cs_o %b while CPU clock high at %h",
                                            io_cs_o, addr));
            if (!we) begin
                assert (cpu_data_o == expected)
                    else report_error($sformatf("cpu_data_o %h, expected %h at %h",
                                                cpu_data_o, expected, addr));
            end
        end
    endtask

    task automatic load_random_bytes(input int count);
        logic [AW-1:0] addr;
        for (int i = 0; i < count; i++) begin
            addr = rand_addr_in(0, MEM_SIZE);
            host_access(1'b1, addr, rand_byte());
            written_q.push_back(addr);
            if (addr[AW-1:AW-4] < `PET_ROM_REGION) begin
                low_pool.push_back(addr);
            end
        end
        foreach (written_q[i]) begin
            host_access(1'b0, written_q[i], '0);
        end
    endtask

    task automatic exercise_cpu_ram(input int frames);
        logic [AW-1:0] addr;
        for (int i = 0; i < frames; i++) begin
            if (rand_bit() || low_pool.size() == 0) begin
                addr = rand_addr_in(0, ROM_BASE);
                cpu_frame(1'b1, addr, rand_byte());
                low_pool.push_back(addr);
            end else begin
                addr = low_pool[rand_index(low_pool.size())];
                cpu_frame(1'b0, addr, rand_byte());
            end
        end
    endtask

    task automatic check_rom_protect(input int count);
        logic [AW-1:0] rom_q [$];
        logic [AW-1:0] addr;
        for (int i = 0; i < count; i++) begin
            addr = rand_addr_in(ROM_BASE, MEM_SIZE - ROM_BASE);
            // Keep out of the I/O page
            if (addr[AW-1:8] == `PET_IO_PAGE) begin
                addr[8] = ~addr[8];
            end
            rom_q.push_back(addr);
            host_access(1'b1, addr, rand_byte());
        end
        foreach (rom_q[i]) begin
            cpu_frame(1'b1, rom_q[i], ~mem_model[rom_q[i]]);
        end
        foreach (rom_q[i]) begin
            host_access(1'b0, rom_q[i], '0);
        end
        foreach (rom_q[i]) begin
            cpu_frame(1'b0, rom_q[i], '0);
        end
    endtask

    task automatic check_io_page(input int count);
        logic [AW-1:0] io_q [$];
        logic [AW-1:0] addr;
        for (int i = 0; i < count; i++) begin
            addr = {`PET_IO_PAGE, rand_byte()};
            io_q.push_back(addr);
            host_access(1'b1, addr, rand_byte());
        end
        foreach (io_q[i]) begin
            cpu_frame(1'b1, io_q[i], ~mem_model[io_q[i]]);
            cpu_frame(1'b0, io_q[i], '0);
        end
        foreach (io_q[i]) begin
            host_access(1'b0, io_q[i], '0);
        end
    endtask

    task automatic cpu_traffic(input int frames);
        logic [AW-1:0] addr;
        for (int i = 0; i < frames; i++) begin
            if (rand_bit() || cpu_pool.size() == 0) begin
                addr = rand_addr_in(CPU_BASE, REGION_SPAN);
                cpu_frame(1'b1, addr, rand_byte());
                cpu_pool.push_back(addr);
            end else begin
                addr = cpu_pool[rand_index(cpu_pool.size())];
                cpu_frame(1'b0, addr, '0);
            end
        end
    endtask

    task automatic host_traffic(input int ops);
        logic [AW-1:0] addr;
        for (int i = 0; i < ops; i++) begin
            if (rand_bit() || host_pool.size() == 0) begin
                addr = rand_addr_in(HOST_BASE, REGION_SPAN);
                host_access(1'b1, addr, rand_byte());
                host_pool.push_back(addr);
            end else begin
                addr = host_pool[rand_index(host_pool.size())];
                host_access(1'b0, addr, '0);
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sys_clock_i);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed          = 32'he765_1f0a;
        rst_i         = 1'b1;
        cpu_addr_i    = '0;
        cpu_data_i    = '0;
        cpu_we_i      = 1'b0;
        io_data_i     = '0;
        host_valid_i  = 1'b0;
        host_addr_i   = '0;
        host_wdata_i  = '0;
        host_we_i     = 1'b0;
        host_rready_i = 1'b0;
        repeat (16) @(posedge sys_clock_i);
        rst_i <= 1'b0;
        @(negedge sys_clock_i);
        assert (host_ready_o) else report_error("host_ready_o low after reset");
        assert (!host_rvalid_o) else report_error("host_rvalid_o high after reset");
        assert (!io_cs_o) else report_error("io_cs_o high after reset");

        load_random_bytes(500);
        exercise_cpu_ram(1000);
        check_rom_protect(32);
        check_io_page(16);
        // Host and CPU on disjoint halves of the low 32 KiB
        fork
            cpu_traffic(1000);
            host_traffic(600);
        join

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* hw/bus_arbiter.sv */
// Fixed-slot arbiter for the shared RAM.
// The CPU owns its slot outright; the host gets every other cycle it asks for,
// and the CPU slot too when the CPU is idle.
// RAM read data is returned one cycle after the grant to its owner only.

`include "pet_config.svh"

module bus_arbiter
    import pet_pkg::*;
(
    input  logic                       sys_clock_i,
    input  logic                       rst_i,
    input  phase_t                     phase_i,
    input  logic                       cpu_req_i,
    input  logic                       cpu_we_i,
    input  logic [`PET_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [`PET_DATA_WIDTH-1:0] cpu_wdata_i,
    input  logic                       hreq_i,
    input  logic                       hwe_i,
    input  logic [`PET_ADDR_WIDTH-1:0] haddr_i,
    input  logic [`PET_DATA_WIDTH-1:0] hwdata_i,
    output logic                       hgnt_o,
    output logic                       cpu_rvalid_o,
    output logic                       host_rvalid_o,
    output logic [`PET_DATA_WIDTH-1:0] mem_rdata_o,
    output logic                       ram_en_o,
    output logic                       ram_we_o,
    output logic [`PET_ADDR_WIDTH-1:0] ram_addr_o,
    output logic [`PET_DATA_WIDTH-1:0] ram_wdata_o,
    input  logic [`PET_DATA_WIDTH-1:0] ram_rdata_i
);

    logic cpu_slot;
    logic cpu_gnt;
    logic cpu_pend_q;
    logic host_pend_q;

    assign cpu_slot = (phase_i == phase_t'(`PET_CPU_SLOT));
    assign cpu_gnt  = cpu_req_i && cpu_slot;
    assign hgnt_o   = hreq_i && !cpu_gnt;

    assign ram_en_o    = cpu_gnt || hgnt_o;
    assign ram_we_o    = cpu_gnt ? cpu_we_i : (hgnt_o && hwe_i);
    assign ram_addr_o  = cpu_gnt ? cpu_addr_i : haddr_i;
    assign ram_wdata_o = cpu_gnt ? cpu_wdata_i : hwdata_i;

    // Owner of the access now in the RAM output register
    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            cpu_pend_q  <= 1'b0;
            host_pend_q <= 1'b0;
        end else begin
            cpu_pend_q  <= cpu_gnt;
            host_pend_q <= hgnt_o;
        end
    end

    assign cpu_rvalid_o  = cpu_pend_q;
    assign host_rvalid_o = host_pend_q;
    assign mem_rdata_o   = ram_rdata_i;

    // A CPU request outside its slot would be dropped
    a_cpu_never_refused: assert property (
        @(posedge sys_clock_i) disable iff (rst_i)
        cpu_req_i |-> cpu_slot
    );

endmodule

/* hw/bus_timing.sv */
// Free-running frame timing for the shared bus.
// The CPU clock is low for the first half of a frame and high for the second.
// Both outputs come straight from flops, so the CPU clock has no glitches.

`include "pet_config.svh"

module bus_timing
    import pet_pkg::*;
(
    input  logic   sys_clock_i,
    input  logic   rst_i,
    output phase_t phase_o,
    output logic   cpu_clock_o
);

    localparam phase_t LAST_PHASE = phase_t'(`PET_FRAME_CYCLES - 1);
    localparam phase_t HIGH_PHASE = phase_t'(`PET_FRAME_CYCLES / 2);

    phase_t phase_q;
    phase_t phase_next;
    logic   cpu_clock_q;

    assign phase_next = (phase_q == LAST_PHASE) ? '0 : phase_q + phase_t'(1);

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            phase_q     <= '0;
            cpu_clock_q <= 1'b0;
        end else begin
            phase_q     <= phase_next;
            // Follows the phase being entered, not the current one
            cpu_clock_q <= (phase_next >= HIGH_PHASE);
        end
    end

    assign phase_o     = phase_q;
    assign cpu_clock_o = cpu_clock_q;

endmodule

/* hw/cpu_port.sv */
// CPU side of the shared bus.
// CPU inputs must hold for the whole frame; they are sampled at the end of
// the phase before the CPU slot.
// Writes to ROM or the I/O page never become memory requests.
// Read data shows up while the CPU clock is high and holds to the next frame.

`include "pet_config.svh"

module cpu_port
    import pet_pkg::*;
(
    input  logic                       sys_clock_i,
    input  logic                       rst_i,
    input  phase_t                     phase_i,
    input  logic [`PET_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [`PET_DATA_WIDTH-1:0] cpu_data_i,
    input  logic                       cpu_we_i,
    input  logic [`PET_DATA_WIDTH-1:0] io_data_i,
    output logic [`PET_DATA_WIDTH-1:0] cpu_data_o,
    output logic                       io_cs_o,
    output logic                       req_o,
    output logic                       req_we_o,
    output logic [`PET_ADDR_WIDTH-1:0] req_addr_o,
    output logic [`PET_DATA_WIDTH-1:0] req_wdata_o,
    input  logic [`PET_DATA_WIDTH-1:0] mem_rdata_i,
    input  logic                       mem_rvalid_i
);

    localparam phase_t SAMPLE_PHASE = phase_t'(`PET_CPU_SLOT - 1);
    localparam phase_t SLOT_PHASE   = phase_t'(`PET_CPU_SLOT);
    localparam phase_t LAST_PHASE   = phase_t'(`PET_FRAME_CYCLES - 1);

    cpu_addr_u                  addr_d;
    cpu_addr_u                  addr_q;
    logic                       is_io;
    logic                       is_rom;
    logic                       req_q;
    logic                       io_q;
    logic                       we_q;
    logic [`PET_DATA_WIDTH-1:0] wdata_q;
    logic [`PET_DATA_WIDTH-1:0] rdata_q;

    // Page view for the I/O test, region view for the ROM test
    assign addr_d.flat = cpu_addr_i;
    assign is_io  = (addr_d.page_view.page == `PET_IO_PAGE);
    assign is_rom = (addr_d.region_view.region >= `PET_ROM_REGION) && !is_io;

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            req_q <= 1'b0;
            io_q  <= 1'b0;
        end else if (phase_i == SAMPLE_PHASE) begin
            req_q <= !is_io && !(is_rom && cpu_we_i);
            io_q  <= is_io;
        end else begin
            req_q <= 1'b0;
            // Chip select drops once the frame is over
            if (phase_i == LAST_PHASE) begin
                io_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (phase_i == SAMPLE_PHASE) begin
            addr_q  <= addr_d;
            we_q    <= cpu_we_i;
            wdata_q <= cpu_data_i;
        end
        if (mem_rvalid_i) begin
            rdata_q <= mem_rdata_i;
        end else if (io_q && phase_i == SLOT_PHASE) begin
            rdata_q <= io_data_i;
        end
    end

    // RAM data passes through in the cycle it arrives
    assign cpu_data_o  = mem_rvalid_i ? mem_rdata_i : rdata_q;
    assign io_cs_o     = io_q;
    assign req_o       = req_q;
    assign req_we_o    = we_q;
    assign req_addr_o  = addr_q.flat;
    assign req_wdata_o = wdata_q;

    a_req_in_slot: assert property (
        @(posedge sys_clock_i) disable iff (rst_i)
        req_o |-> phase_i == SLOT_PHASE
    );

endmodule

/* hw/host_port.sv */
// Host request/response port with a single access in flight.
// A new request is accepted only when nothing is pending or unread.
// Writes answer with the byte written; the response holds until taken.

`include "pet_config.svh"

module host_port (
    input  logic                       sys_clock_i,
    input  logic                       rst_i,
    input  logic                       host_valid_i,
    output logic                       host_ready_o,
    input  logic [`PET_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [`PET_DATA_WIDTH-1:0] host_wdata_i,
    input  logic                       host_we_i,
    output logic                       host_rvalid_o,
    input  logic                       host_rready_i,
    output logic [`PET_DATA_WIDTH-1:0] host_rdata_o,
    output logic                       hreq_o,
    output logic                       hwe_o,
    output logic [`PET_ADDR_WIDTH-1:0] haddr_o,
    output logic [`PET_DATA_WIDTH-1:0] hwdata_o,
    input  logic                       hgnt_i,
    input  logic [`PET_DATA_WIDTH-1:0] mem_rdata_i,
    input  logic                       mem_rvalid_i
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_RESP = 2'd2;

    logic [1:0]                 state_q;
    logic                       we_q;
    logic [`PET_ADDR_WIDTH-1:0] addr_q;
    logic [`PET_DATA_WIDTH-1:0] wdata_q;
    logic [`PET_DATA_WIDTH-1:0] rdata_q;

    always_ff @(posedge sys_clock_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (host_valid_i) state_q <= ST_WAIT;
                ST_WAIT: if (hgnt_i) state_q <= ST_RESP;
                ST_RESP: if (host_rready_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (host_ready_o && host_valid_i) begin
            we_q    <= host_we_i;
            addr_q  <= host_addr_i;
            wdata_q <= host_wdata_i;
        end
        if (mem_rvalid_i) begin
            rdata_q <= mem_rdata_i;
        end
    end

    assign host_ready_o  = (state_q == ST_IDLE);
    assign hreq_o        = (state_q == ST_WAIT);
    assign hwe_o         = we_q;
    assign haddr_o       = addr_q;
    assign hwdata_o      = wdata_q;
    assign host_rvalid_o = (state_q == ST_RESP);
    // First response cycle takes the byte straight from RAM
    assign host_rdata_o  = mem_rvalid_i ? mem_rdata_i : rdata_q;

    a_resp_stable: assert property (
        @(posedge sys_clock_i) disable iff (rst_i)
        host_rvalid_o && !host_rready_i |=> host_rvalid_o && $stable(host_rdata_o)
    );

endmodule

/* hw/pet_bus.sv */
// Top of the PET bus core: timing, CPU and host ports, arbiter and RAM.
// The host sees all of memory as RAM; only CPU writes are write-protected.
// Host port is the parallel side of the serial link, which sits outside.

`include "pet_config.svh"

module pet_bus
    import pet_pkg::*;
(
    input  logic                       sys_clock_i,
    input  logic                       rst_i,
    output logic                       cpu_clock_o,
    input  logic [`PET_ADDR_WIDTH-1:0] cpu_addr_i,
    input  logic [`PET_DATA_WIDTH-1:0] cpu_data_i,
    input  logic                       cpu_we_i,
    output logic [`PET_DATA_WIDTH-1:0] cpu_data_o,
    output logic                       io_cs_o,
    input  logic [`PET_DATA_WIDTH-1:0] io_data_i,
    input  logic                       host_valid_i,
    output logic                       host_ready_o,
    input  logic [`PET_ADDR_WIDTH-1:0] host_addr_i,
    input  logic [`PET_DATA_WIDTH-1:0] host_wdata_i,
    input  logic                       host_we_i,
    output logic                       host_rvalid_o,
    input  logic                       host_rready_i,
    output logic [`PET_DATA_WIDTH-1:0] host_rdata_o
);

    phase_t                     phase;
    logic                       cpu_req;
    logic                       cpu_we;
    logic [`PET_ADDR_WIDTH-1:0] cpu_addr;
    logic [`PET_DATA_WIDTH-1:0] cpu_wdata;
    logic                       hreq;
    logic                       hwe;
    logic [`PET_ADDR_WIDTH-1:0] haddr;
    logic [`PET_DATA_WIDTH-1:0] hwdata;
    logic                       hgnt;
    logic                       cpu_mem_rvalid;
    logic                       host_mem_rvalid;
    logic [`PET_DATA_WIDTH-1:0] mem_rdata;
    logic                       ram_en;
    logic                       ram_we;
    logic [`PET_ADDR_WIDTH-1:0] ram_addr;
    logic [`PET_DATA_WIDTH-1:0] ram_wdata;
    logic [`PET_DATA_WIDTH-1:0] ram_rdata;

    bus_timing bus_timing_inst (
        .sys_clock_i(sys_clock_i),
        .rst_i      (rst_i),
        .phase_o    (phase),
        .cpu_clock_o(cpu_clock_o)
    );

    cpu_port cpu_port_inst (
        .sys_clock_i (sys_clock_i),
        .rst_i       (rst_i),
        .phase_i     (phase),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_data_i  (cpu_data_i),
        .cpu_we_i    (cpu_we_i),
        .io_data_i   (io_data_i),
        .cpu_data_o  (cpu_data_o),
        .io_cs_o     (io_cs_o),
        .req_o       (cpu_req),
        .req_we_o    (cpu_we),
        .req_addr_o  (cpu_addr),
        .req_wdata_o (cpu_wdata),
        .mem_rdata_i (mem_rdata),
        .mem_rvalid_i(cpu_mem_rvalid)
    );

    host_port host_port_inst (
        .sys_clock_i  (sys_clock_i),
        .rst_i        (rst_i),
        .host_valid_i (host_valid_i),
        .host_ready_o (host_ready_o),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_we_i    (host_we_i),
        .host_rvalid_o(host_rvalid_o),
        .host_rready_i(host_rready_i),
        .host_rdata_o (host_rdata_o),
        .hreq_o       (hreq),
        .hwe_o        (hwe),
        .haddr_o      (haddr),
        .hwdata_o     (hwdata),
        .hgnt_i       (hgnt),
        .mem_rdata_i  (mem_rdata),
        .mem_rvalid_i (host_mem_rvalid)
    );

    bus_arbiter bus_arbiter_inst (
        .sys_clock_i  (sys_clock_i),
        .rst_i        (rst_i),
        .phase_i      (phase),
        .cpu_req_i    (cpu_req),
        .cpu_we_i     (cpu_we),
        .cpu_addr_i   (cpu_addr),
        .cpu_wdata_i  (cpu_wdata),
        .hreq_i       (hreq),
        .hwe_i        (hwe),
        .haddr_i      (haddr),
        .hwdata_i     (hwdata),
        .hgnt_o       (hgnt),
        .cpu_rvalid_o (cpu_mem_rvalid),
        .host_rvalid_o(host_mem_rvalid),
        .mem_rdata_o  (mem_rdata),
        .ram_en_o     (ram_en),
        .ram_we_o     (ram_we),
        .ram_addr_o   (ram_addr),
        .ram_wdata_o  (ram_wdata),
        .ram_rdata_i  (ram_rdata)
    );

    pet_ram pet_ram_inst (
        .sys_clock_i(sys_clock_i),
        .en_i       (ram_en),
        .we_i       (ram_we),
        .addr_i     (ram_addr),
        .wdata_i    (ram_wdata),
        .rdata_o    (ram_rdata)
    );

endmodule

/* hw/pet_config.svh */
// Build-time parameters of the PET bus core.
// PET_FRAME_CYCLES must be a power of two no larger than 4 to fit phase_t,
// and PET_CPU_SLOT must be at least 1.
// Region and page values assume the stock 16-bit PET memory map.

`ifndef PET_CONFIG_SVH
`define PET_CONFIG_SVH

`define PET_ADDR_WIDTH 16
`define PET_DATA_WIDTH 8

// System clocks per CPU clock, and the phase in which the CPU owns the RAM
`define PET_FRAME_CYCLES 4
`define PET_CPU_SLOT 1

// Top nibble where write-protected ROM begins ($B000)
`define PET_ROM_REGION 4'hB
`define PET_IO_PAGE 8'hE8

`endif

/* hw/pet_pkg.sv */
// Types shared by the PET bus core and its testbench.
// The address union assumes an address wider than 8 bits.
// Region decoding uses the top nibble only.

`include "pet_config.svh"

package pet_pkg;

    // Position inside a CPU frame
    typedef logic [$clog2(`PET_FRAME_CYCLES)-1:0] phase_t;

    // One CPU address, seen flat, as page/offset or as region/offset
    typedef union packed {
        logic [`PET_ADDR_WIDTH-1:0] flat;
        struct packed {
            logic [`PET_ADDR_WIDTH-9:0] page;
            logic [7:0]                 offset;
        } page_view;
        struct packed {
            logic [3:0]                 region;
            logic [`PET_ADDR_WIDTH-5:0] offset;
        } region_view;
    } cpu_addr_u;

endpackage

/* hw/pet_ram.sv */
// Single-port byte RAM covering the full CPU address space.
// One cycle read latency; a write also loads the written byte to the output.
// Contents are undefined after power-up.

`include "pet_config.svh"

module pet_ram (
    input  logic                       sys_clock_i,
    input  logic                       en_i,
    input  logic                       we_i,
    input  logic [`PET_ADDR_WIDTH-1:0] addr_i,
    input  logic [`PET_DATA_WIDTH-1:0] wdata_i,
    output logic [`PET_DATA_WIDTH-1:0] rdata_o
);

    localparam int DEPTH = 2 ** `PET_ADDR_WIDTH;

    logic [`PET_DATA_WIDTH-1:0] mem [0:DEPTH-1];
    logic [`PET_DATA_WIDTH-1:0] rdata_q;

    always_ff @(posedge sys_clock_i) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
                rdata_q     <= wdata_i;
            end else begin
                rdata_q <= mem[addr_i];
            end
        end
    end

    assign rdata_o = rdata_q;

    a_addr_known: assert property (
        @(posedge sys_clock_i) en_i |-> !$isunknown(addr_i)
    );

endmodule

/* pet_bus.f */
+incdir+hw
hw/pet_pkg.sv
hw/bus_timing.sv
hw/cpu_port.sv
hw/host_port.sv
hw/bus_arbiter.sv
hw/pet_ram.sv
hw/pet_bus.sv
dv/pet_bus_tb.sv
